// File: front_end.f
+incdir+common
common/frontend_pkg.sv
branch_predictor/gshare.sv
branch_predictor/btb.sv
branch_predictor/branch_predictor.sv
logic/pc_gen_stage.sv
logic/fetch_stage.sv
logic/front_end.sv
testbench/front_end_assert.sv
testbench/tb_front_end.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the front end testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert --top-module tb_front_end \
  -f front_end.f -Mdir obj_dir -o sim_front_end > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
  echo "Build failed, see $BUILD_LOG"
  exit 1
fi

./obj_dir/sim_front_end > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"

if grep -q "=== FAIL ===" "$SIM_LOG"; then
  echo "Simulation reported failure"
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi
exit 0

// File: testbench/tb_front_end.sv
// Directed front end tests; the cache model keeps one request outstanding, decode is driven here
`include "frontend_config.svh"

module tb_front_end
  import frontend_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  logic             clk_i;
  logic             rst_i;
  logic             flush_i;
  logic             except_i;
  logic [`XLEN-1:0] except_pc_i;
  logic [`XLEN-1:0] addr_o;
  logic             addr_valid_o;
  logic             addr_ready_i;
  icache_out_t      data_i;
  logic             data_valid_i;
  logic             data_ready_o;
  logic             issue_ready_i;
  logic             issue_valid_o;
  logic [`ILEN-1:0] instruction_o;
  prediction_t      pred_o;
  resolution_t      res_i;

  // Words seen by decode, in order
  logic [`ILEN-1:0] got_instr [$];
  prediction_t      got_pred [$];

  // Reference predictor state
  logic [1:0]       m_cnt [1 << `HLEN];
  logic [`HLEN-1:0] m_ghr;
  logic             m_btb_valid [1 << `BTB_BITS];
  logic [`XLEN-1:0] m_btb_pc [1 << `BTB_BITS];
  logic [`XLEN-1:0] m_btb_target [1 << `BTB_BITS];

  front_end i_dut (.*);

  always #5 clk_i = ~clk_i;

  // Decode side monitor
  always @(posedge clk_i) begin
    if (!rst_i && issue_valid_o && issue_ready_i) begin
      got_instr.push_back(instruction_o);
      got_pred.push_back(pred_o);
    end
  end

  task automatic abort_run(input string msg);
    $display("ERROR %s", msg);
    $display("=== FAIL ===");
    $fatal(1, "Simulation stopped after an error");
  endtask

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("ERROR %s: expected %h, actual %h", name, exp, act);
      $display("=== FAIL ===");
      $fatal(1, "Simulation stopped after a mismatch");
    end
  endtask

  // Counter index uses the history before the shift
  task automatic train_model(input logic taken, input logic [`XLEN-1:0] pc,
                             input logic [`XLEN-1:0] target);
    logic [`HLEN-1:0] idx;
    logic [`BTB_BITS-1:0] bidx;
    idx = pc[`HLEN+1:2] ^ m_ghr;
    bidx = pc[`BTB_BITS+1:2];
    if (taken && m_cnt[idx] != 2'd3) m_cnt[idx] = m_cnt[idx] + 2'd1;
    if (!taken && m_cnt[idx] != 2'd0) m_cnt[idx] = m_cnt[idx] - 2'd1;
    m_ghr = {m_ghr[`HLEN-2:0], taken};
    if (taken) begin
      m_btb_valid[bidx] = 1'b1;
      m_btb_pc[bidx] = pc;
      m_btb_target[bidx] = target;
    end
  endtask

  // BTB hit needs a valid entry with the same upper PC bits
  function automatic logic model_hit(input logic [`XLEN-1:0] pc);
    logic [`BTB_BITS-1:0] bidx;
    bidx = pc[`BTB_BITS+1:2];
    return m_btb_valid[bidx] &&
           (m_btb_pc[bidx][`XLEN-1:`BTB_BITS+2] == pc[`XLEN-1:`BTB_BITS+2]);
  endfunction

  // Taken needs a strong enough counter and a matching BTB entry
  function automatic logic model_taken(input logic [`XLEN-1:0] pc);
    return (m_cnt[pc[`HLEN+1:2] ^ m_ghr] >= 2'd2) && model_hit(pc);
  endfunction

  task automatic clear_seen();
    got_instr.delete();
    got_pred.delete();
  endtask

  task automatic wait_items(input int n, input string name);
    int cycles;
    cycles = 0;
    while (got_pred.size() < n) begin
      @(posedge clk_i);
      cycles++;
      if (cycles > 500) abort_run({"timed out waiting for instructions in ", name});
    end
  endtask

  // Cache model with random accept and response delays
  task automatic cache_model();
    logic [`XLEN-1:0] addr;
    int cycles;
    forever begin
      repeat ($urandom_range(3, 0)) @(negedge clk_i);
      addr_ready_i = 1'b1;
      cycles = 0;
      do begin
        @(posedge clk_i);
        cycles++;
        if (cycles > 200) abort_run("cache model saw no fetch address");
      end while (!addr_valid_o);
      addr = addr_o;
      @(negedge clk_i);
      addr_ready_i = 1'b0;
      repeat ($urandom_range(3, 0)) @(negedge clk_i);
      data_i.instruction = addr ^ 32'hA5A5_A5A5;
      data_valid_i = 1'b1;
      cycles = 0;
      do begin
        @(posedge clk_i);
        cycles++;
        if (cycles > 200) abort_run("front end never took the cache response");
      end while (!data_ready_o);
      @(negedge clk_i);
      data_valid_i = 1'b0;
    end
  endtask

  task automatic raise_exception(input logic [`XLEN-1:0] pc);
    @(negedge clk_i);
    except_i = 1'b1;
    flush_i = 1'b1;
    except_pc_i = pc;
    @(negedge clk_i);
    except_i = 1'b0;
    flush_i = 1'b0;
    clear_seen();
  endtask

  task automatic resolve(input logic mispredict, input logic taken,
                         input logic [`XLEN-1:0] pc, input logic [`XLEN-1:0] target);
    @(negedge clk_i);
    res_i = '{valid: 1'b1, mispredict: mispredict, taken: taken, pc: pc, target: target};
    flush_i = mispredict;
    train_model(taken, pc, target);
    @(negedge clk_i);
    res_i = '0;
    flush_i = 1'b0;
    if (mispredict) clear_seen();
  endtask

  // Path follows the reference prediction for each delivered PC
  task automatic check_stream(input string name, input logic [`XLEN-1:0] start, input int n);
    logic [`XLEN-1:0] exp_pc;
    wait_items(n, name);
    exp_pc = start;
    for (int i = 0; i < n; i++) begin
      check_value({name, " pc"}, exp_pc, got_pred[i].pc);
      check_value({name, " instruction"}, exp_pc ^ 32'hA5A5_A5A5, got_instr[i]);
      check_value({name, " hit"}, 32'(model_hit(exp_pc)), 32'(got_pred[i].hit));
      if (model_hit(exp_pc)) begin
        check_value({name, " target"}, m_btb_target[exp_pc[`BTB_BITS+1:2]],
                    got_pred[i].target);
      end
      check_value({name, " taken"}, 32'(model_taken(exp_pc)), 32'(got_pred[i].taken));
      exp_pc = model_taken(exp_pc) ? m_btb_target[exp_pc[`BTB_BITS+1:2]] : exp_pc + 32'd4;
    end
  endtask

  task automatic test_sequential();
    check_stream("sequential", `BOOT_PC, 8);
  endtask

  // Stream since reset is still sequential, so the whole list is checked from BOOT_PC
  task automatic test_back_pressure();
    int cycles;
    int n0;
    @(negedge clk_i);
    n0 = got_pred.size();
    cycles = 0;
    while (got_pred.size() < n0 + 12) begin
      issue_ready_i = 1'($urandom_range(1, 0));
      repeat ($urandom_range(4, 1)) @(negedge clk_i);
      cycles++;
      if (cycles > 400) abort_run("back pressure test made no progress");
    end
    issue_ready_i = 1'b1;
    check_stream("back_pressure", `BOOT_PC, n0 + 12);
  endtask

  task automatic test_exception();
    raise_exception(32'h0000_2000);
    check_stream("exception", 32'h0000_2000, 6);
  endtask

  task automatic test_mispredict();
    resolve(1'b1, 1'b1, 32'h0000_1500, 32'h0000_3000);
    check_stream("mispredict_taken", 32'h0000_3000, 5);
    resolve(1'b1, 1'b0, 32'h0000_4000, 32'h0000_4100);
    check_stream("mispredict_not_taken", 32'h0000_4004, 5);
  endtask

  // With this history the lookup at P lands on a counter that is already weakly taken
  task automatic test_training();
    resolve(1'b0, 1'b1, 32'h0000_502C, 32'h0000_6000);
    resolve(1'b0, 1'b1, 32'h0000_502C, 32'h0000_6000);
    raise_exception(32'h0000_5024);
    check_stream("training", 32'h0000_5024, 6);
  endtask

  initial begin
    void'($urandom(32422));
    clk_i = 1'b0;
    rst_i = 1'b1;
    flush_i = 1'b0;
    except_i = 1'b0;
    except_pc_i = '0;
    addr_ready_i = 1'b0;
    data_i = '0;
    data_valid_i = 1'b0;
    issue_ready_i = 1'b1;
    res_i = '0;
    m_ghr = '0;
    for (int i = 0; i < (1 << `HLEN); i++) m_cnt[i] = 2'd1;
    for (int i = 0; i < (1 << `BTB_BITS); i++) begin
      m_btb_valid[i] = 1'b0;
      m_btb_pc[i] = '0;
      m_btb_target[i] = '0;
    end
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;
    fork
      cache_model();
    join_none
    test_sequential();
    test_back_pressure();
    test_exception();
    test_mispredict();
    test_training();
    $display("=== PASS ===");
    $finish;
  end

endmodule

// File: testbench/front_end_assert.sv
// Handshake and reset properties for front_end; a redirect may change a pending address
`include "frontend_config.svh"

module front_end_assert
  import frontend_pkg::*;
(
  input logic             clk_i,
  input logic             rst_i,
  input logic             flush_i,
  input logic [`XLEN-1:0] addr_o,
  input logic             addr_valid_o,
  input logic             addr_ready_i,
  input logic             data_ready_o,
  input logic             issue_ready_i,
  input logic             issue_valid_o,
  input logic [`ILEN-1:0] instruction_o,
  input prediction_t      pred_o
);

  timeunit 1ns;
  timeprecision 1ps;

  // Pending address holds unless a flush redirects it
  addr_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    addr_valid_o && !addr_ready_i && !flush_i |=> $stable(addr_o))
    else $error("fetch address changed while waiting for the cache");

  // Decode sees the same item until it takes it
  issue_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    issue_valid_o && !issue_ready_i && !flush_i |=>
      issue_valid_o && $stable(instruction_o) && $stable(pred_o))
    else $error("decode output changed under back-pressure");

  // No valid out of a reset edge
  reset_quiet: assert property (@(posedge clk_i)
    rst_i |=> !addr_valid_o && !data_ready_o && !issue_valid_o)
    else $error("valid output high after a reset edge");

endmodule

bind front_end front_end_assert i_front_end_assert (.*);

// File: logic/front_end.sv
// Fetch front end top; flush_i must come with except_i or a mispredicting resolution
`include "frontend_config.svh"

module front_end
  import frontend_pkg::*;
(
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic             flush_i,
  input  logic             except_i,
  input  logic [`XLEN-1:0] except_pc_i,

  // Instruction cache
  output logic [`XLEN-1:0] addr_o,
  output logic             addr_valid_o,
  input  logic             addr_ready_i,
  input  icache_out_t      data_i,
  input  logic             data_valid_i,
  output logic             data_ready_o,

  // Decode
  input  logic             issue_ready_i,
  output logic             issue_valid_o,
  output logic [`ILEN-1:0] instruction_o,
  output prediction_t      pred_o,

  // Branch unit
  input  resolution_t      res_i
);

  logic [`XLEN-1:0] pc;
  prediction_t      pred;
  logic             fetch_ready;

  pc_gen_stage u_pc_gen_stage (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .except_i      (except_i),
    .except_pc_i   (except_pc_i),
    .res_i         (res_i),
    .pred_i        (pred),
    .fetch_ready_i (fetch_ready),
    .pc_o          (pc)
  );

  // Lookup on the PC being fetched right now
  branch_predictor u_branch_predictor (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .pc_i   (pc),
    .res_i  (res_i),
    .pred_o (pred)
  );

  fetch_stage u_fetch_stage (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .flush_i       (flush_i),
    .pc_i          (pc),
    .pred_i        (pred),
    .fetch_ready_o (fetch_ready),
    .addr_o        (addr_o),
    .addr_valid_o  (addr_valid_o),
    .addr_ready_i  (addr_ready_i),
    .data_i        (data_i),
    .data_valid_i  (data_valid_i),
    .data_ready_o  (data_ready_o),
    .issue_ready_i (issue_ready_i),
    .issue_valid_o (issue_valid_o),
    .instruction_o (instruction_o),
    .pred_o        (pred_o)
  );

endmodule

// File: logic/fetch_stage.sv
// One outstanding cache request plus one output slot; a redirect may replace a pending address
`include "frontend_config.svh"

module fetch_stage
  import frontend_pkg::*;
(
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic             flush_i,

  // From PC generator and predictor
  input  logic [`XLEN-1:0] pc_i,
  input  prediction_t      pred_i,
  output logic             fetch_ready_o,

  // Cache request channel
  output logic [`XLEN-1:0] addr_o,
  output logic             addr_valid_o,
  input  logic             addr_ready_i,

  // Cache response channel
  input  icache_out_t      data_i,
  input  logic             data_valid_i,
  output logic             data_ready_o,

  // Decode channel
  input  logic             issue_ready_i,
  output logic             issue_valid_o,
  output logic [`ILEN-1:0] instruction_o,
  output prediction_t      pred_o
);

  // Low in reset and the cycle right after it
  logic             run_q;

  // In-flight slot
  logic             infl_valid_q;
  logic             infl_stale_q;
  prediction_t      infl_pred_q;

  // Output register toward decode
  logic             out_valid_q;
  logic [`ILEN-1:0] out_instr_q;
  prediction_t      out_pred_q;

  logic             addr_fire;
  logic             resp_fire;
  logic             resp_keep;

  // Issue only with an empty in-flight slot
  assign addr_valid_o  = run_q && !infl_valid_q;
  assign addr_o        = pc_i;
  assign addr_fire     = addr_valid_o && addr_ready_i;
  assign fetch_ready_o = addr_fire;

  // Stale words are always taken so they can be thrown away
  assign data_ready_o = run_q && infl_valid_q &&
                        (infl_stale_q || !out_valid_q || issue_ready_i);
  assign resp_fire    = data_valid_i && data_ready_o;
  // Word survives only if no flush hit it
  assign resp_keep    = resp_fire && !infl_stale_q && !flush_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      run_q <= 1'b0;
    end else begin
      run_q <= 1'b1;
    end
  end

  // In-flight control
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      infl_valid_q <= 1'b0;
      infl_stale_q <= 1'b0;
    end else if (addr_fire) begin
      infl_valid_q <= 1'b1;
      // Address taken in a flush cycle is already on the wrong path
      infl_stale_q <= flush_i;
    end else if (resp_fire) begin
      infl_valid_q <= 1'b0;
      infl_stale_q <= 1'b0;
    end else if (flush_i && infl_valid_q) begin
      infl_stale_q <= 1'b1;
    end
  end

  // Prediction made for the address at acceptance
  always_ff @(posedge clk_i) begin
    if (addr_fire) begin
      infl_pred_q <= pred_i;
    end
  end

  // Output valid
  always_ff @(posedge clk_i) begin
    if (rst_i || flush_i) begin
      out_valid_q <= 1'b0;
    end else if (resp_keep) begin
      out_valid_q <= 1'b1;
    end else if (issue_ready_i) begin
      out_valid_q <= 1'b0;
    end
  end

  // Output payload, loaded together with its prediction
  always_ff @(posedge clk_i) begin
    if (resp_keep) begin
      out_instr_q <= data_i.instruction;
      out_pred_q  <= infl_pred_q;
    end
  end

  assign issue_valid_o = out_valid_q;
  assign instruction_o = out_instr_q;
  assign pred_o        = out_pred_q;

endmodule

// File: logic/pc_gen_stage.sv
// Fetch PC register; redirect priority is exception, then misprediction, then prediction
`include "frontend_config.svh"

module pc_gen_stage
  import frontend_pkg::*;
(
  input  logic             clk_i,
  input  logic             rst_i,

  // Back end redirect
  input  logic             except_i,
  input  logic [`XLEN-1:0] except_pc_i,

  // Branch unit redirect
  input  resolution_t      res_i,

  // Prediction for the current PC
  input  prediction_t      pred_i,

  // Pulse when the cache took the current address
  input  logic             fetch_ready_i,

  output logic [`XLEN-1:0] pc_o
);

  logic [`XLEN-1:0] pc_q;
  logic [`XLEN-1:0] pc_d;

  always_comb begin
    pc_d = pc_q;
    if (except_i) begin
      pc_d = except_pc_i;
    end else if (res_i.valid && res_i.mispredict) begin
      // Resume on the actual path of the branch
      pc_d = res_i.taken ? res_i.target : (res_i.pc + INSTR_STEP);
    end else if (fetch_ready_i) begin
      // Follow the predictor, else step to the next word
      pc_d = pred_i.taken ? pred_i.target : (pc_q + INSTR_STEP);
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pc_q <= `BOOT_PC;
    end else begin
      pc_q <= pc_d;
    end
  end

  assign pc_o = pc_q;

endmodule

// File: branch_predictor/branch_predictor.sv
// Combinational lookup from the fetch PC; training lands at the edge after res_i.valid
`include "frontend_config.svh"

module branch_predictor
  import frontend_pkg::*;
(
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic [`XLEN-1:0] pc_i,

  // Resolved branch from the branch unit
  input  resolution_t      res_i,

  output prediction_t      pred_o
);

  logic             gs_taken;
  logic             btb_hit;
  logic [`XLEN-1:0] btb_target;
  logic             btb_wr;

  // Only taken branches carry a target worth keeping
  assign btb_wr = res_i.valid && res_i.taken;

  gshare u_gshare (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .pc_i        (pc_i),
    .res_valid_i (res_i.valid),
    .res_pc_i    (res_i.pc),
    .res_taken_i (res_i.taken),
    .taken_o     (gs_taken)
  );

  btb u_btb (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .pc_i         (pc_i),
    .upd_valid_i  (btb_wr),
    .upd_pc_i     (res_i.pc),
    .upd_target_i (res_i.target),
    .hit_o        (btb_hit),
    .target_o     (btb_target)
  );

  // Taken only when a target is known
  assign pred_o.pc     = pc_i;
  assign pred_o.target = btb_target;
  assign pred_o.hit    = btb_hit;
  assign pred_o.taken  = gs_taken && btb_hit;

endmodule

// File: branch_predictor/btb.sv
// Direct-mapped BTB; a taken update always overwrites its slot, no replacement policy
`include "frontend_config.svh"

module btb
  import frontend_pkg::*;
(
  input  logic             clk_i,
  input  logic             rst_i,

  // Lookup side
  input  logic [`XLEN-1:0] pc_i,

  // Write side, taken branches only
  input  logic             upd_valid_i,
  input  logic [`XLEN-1:0] upd_pc_i,
  input  logic [`XLEN-1:0] upd_target_i,

  output logic             hit_o,
  output logic [`XLEN-1:0] target_o
);

  localparam int unsigned ENTRIES = 1 << `BTB_BITS;

  // Tag and target payload
  btb_entry_t           entry_q [ENTRIES];
  // Valid bits, cleared on reset
  logic [ENTRIES-1:0]   valid_q;

  logic [`BTB_BITS-1:0] rd_idx;
  logic [BTB_TAG_W-1:0] rd_tag;
  logic [`BTB_BITS-1:0] wr_idx;
  logic [BTB_TAG_W-1:0] wr_tag;

  // Index skips the byte offset, tag takes the rest
  assign rd_idx = pc_i[`BTB_BITS+1:2];
  assign rd_tag = pc_i[`XLEN-1:`BTB_BITS+2];
  assign wr_idx = upd_pc_i[`BTB_BITS+1:2];
  assign wr_tag = upd_pc_i[`XLEN-1:`BTB_BITS+2];

  // Hit needs a live entry from the same branch
  assign hit_o    = valid_q[rd_idx] && (entry_q[rd_idx].tag == rd_tag);
  assign target_o = entry_q[rd_idx].target;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q <= '0;
    end else if (upd_valid_i) begin
      valid_q[wr_idx] <= 1'b1;
    end
  end

  // Payload array written alongside the valid bit
  always_ff @(posedge clk_i) begin
    if (upd_valid_i) begin
      entry_q[wr_idx].tag    <= wr_tag;
      entry_q[wr_idx].target <= upd_target_i;
    end
  end

endmodule

// File: branch_predictor/gshare.sv
// Gshare direction predictor; one resolution per cycle, history shared by all branches
`include "frontend_config.svh"

module gshare
  import frontend_pkg::*;
(
  input  logic             clk_i,
  input  logic             rst_i,

  // Lookup side
  input  logic [`XLEN-1:0] pc_i,

  // Training side
  input  logic             res_valid_i,
  input  logic [`XLEN-1:0] res_pc_i,
  input  logic             res_taken_i,

  output logic             taken_o
);

  localparam int unsigned ENTRIES = 1 << `HLEN;

  logic [`HLEN-1:0] ghr_q;
  counter_t         cnt_q [ENTRIES];
  logic [`HLEN-1:0] rd_idx;
  logic [`HLEN-1:0] wr_idx;
  counter_t         cnt_upd;

  // Word index folded with the global history
  assign rd_idx = pc_i[`HLEN+1:2] ^ ghr_q;
  // Training uses the history as it stands before the shift
  assign wr_idx = res_pc_i[`HLEN+1:2] ^ ghr_q;

  // Upper half of the counter range predicts taken
  assign taken_o = (cnt_q[rd_idx] >= CNT_WT);

  // Saturating step toward the resolved direction
  always_comb begin
    cnt_upd = cnt_q[wr_idx];
    if (res_taken_i && (cnt_q[wr_idx] != CNT_ST)) begin
      cnt_upd = cnt_q[wr_idx] + 2'd1;
    end else if (!res_taken_i && (cnt_q[wr_idx] != CNT_SNT)) begin
      cnt_upd = cnt_q[wr_idx] - 2'd1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ghr_q <= '0;
      // All counters start weakly not taken
      for (int i = 0; i < ENTRIES; i++) begin
        cnt_q[i] <= CNT_WNT;
      end
    end else if (res_valid_i) begin
      cnt_q[wr_idx] <= cnt_upd;
      // Newest outcome enters at bit 0
      ghr_q         <= {ghr_q[`HLEN-2:0], res_taken_i};
    end
  end

endmodule

// File: common/frontend_pkg.sv
// Front end types; compile after frontend_config.svh is on the include path, before any RTL
`include "frontend_config.svh"

package frontend_pkg;

  // Byte step between consecutive 32-bit instructions
  localparam logic [`XLEN-1:0] INSTR_STEP = `XLEN'(4);

  // Two-bit saturating counter states
  typedef logic [1:0] counter_t;
  localparam counter_t CNT_SNT = 2'b00;
  localparam counter_t CNT_WNT = 2'b01;
  localparam counter_t CNT_WT  = 2'b10;
  localparam counter_t CNT_ST  = 2'b11;

  // BTB tag covers the PC bits above the index and the byte offset
  localparam int unsigned BTB_TAG_W = `XLEN - `BTB_BITS - 2;

  typedef struct packed {
    logic [BTB_TAG_W-1:0] tag;
    logic [`XLEN-1:0]     target;
  } btb_entry_t;

  // Prediction that travels with each fetched word
  typedef struct packed {
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] target;
    logic             hit;
    logic             taken;
  } prediction_t;

  // Branch outcome from the branch unit
  typedef struct packed {
    logic             valid;
    logic             mispredict;
    logic             taken;
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] target;
  } resolution_t;

  // Cache response payload
  typedef struct packed {
    logic [`ILEN-1:0] instruction;
  } icache_out_t;

endpackage

// File: common/frontend_config.svh
// Build-time sizes for the fetch front end; HLEN >= 2, BTB_BITS + 2 < XLEN, BOOT_PC word aligned
`ifndef FRONTEND_CONFIG_SVH
`define FRONTEND_CONFIG_SVH

// Fetch address width
`define XLEN 32

// Instruction word width, no compressed support
`define ILEN 32

// Global history length, also the gshare index width
`define HLEN 4

// BTB index width
`define BTB_BITS 4

// First fetch address after reset
`define BOOT_PC 32'h0000_1000

`endif
